// ==== logic/issue_consts.svh ====
// opcode, funct7 and register-count macros for the issue stage
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// rv32i major opcodes, bits [6:0] of the instruction word

// register-immediate arithmetic
`define OP_OP_IMM 7'b0010011
// register-register arithmetic, also carries the M extension
`define OP_OP 7'b0110011
// load upper immediate
`define OP_LUI 7'b0110111
// add upper immediate to pc
`define OP_AUIPC 7'b0010111
// jump and link
`define OP_JAL 7'b1101111
// jump and link through register
`define OP_JALR 7'b1100111
// conditional branches
`define OP_BRANCH 7'b1100011
// loads of all widths
`define OP_LOAD 7'b0000011
// stores of all widths
`define OP_STORE 7'b0100011

// funct7 that selects multiply/divide inside OP
`define FUNCT7_MULDIV 7'b0000001

// architectural integer registers
`define NUM_REGS 32
// register address width, log2 of NUM_REGS
`define REG_AW 5

`endif

// ==== logic/issue_pkg.sv ====
// issue_pkg with the opcode enum, unit-flag struct and issue state enum
`default_nettype none

`include "issue_consts.svh"

package issue_pkg;

    // major opcodes the decoder knows about
    // anything else falls to the default branch and is illegal
    typedef enum logic [6:0] {
        OPC_OP_IMM = `OP_OP_IMM,
        OPC_OP     = `OP_OP,
        OPC_LUI    = `OP_LUI,
        OPC_AUIPC  = `OP_AUIPC,
        OPC_JAL    = `OP_JAL,
        OPC_JALR   = `OP_JALR,
        OPC_BRANCH = `OP_BRANCH,
        OPC_LOAD   = `OP_LOAD,
        OPC_STORE  = `OP_STORE
    } rv_opcode_e;

    // target units of one instruction
    // msb first in the order alu, lsu, mul, br
    typedef struct packed {
        // integer arithmetic
        logic alu;
        // load/store
        logic lsu;
        // multiplier
        logic mul;
        // branch / pc redirect
        logic br;
    } unit_flags_t;

    // one-entry issue register occupancy
    typedef enum logic {
        // nothing held, ready for a new word
        EMPTY = 1'b0,
        // a word is held and waits to issue or drop
        HELD  = 1'b1
    } issue_state_e;

endpackage

`default_nettype wire

// ==== logic/decode_if.sv ====
// decode_if carrying unit flags and register usage from decoder to issue control
`default_nettype none

`include "issue_consts.svh"

interface decode_if;

    // units the held word targets, all zero when illegal
    issue_pkg::unit_flags_t units;

    // raw register fields of the held word
    logic [`REG_AW-1:0] rs1_addr;
    logic [`REG_AW-1:0] rs2_addr;
    logic [`REG_AW-1:0] rd_addr;

    // which fields are really read or written
    logic uses_rs1;
    logic uses_rs2;
    logic writes_rd;

    // decoder side drives everything
    modport dec (
        output units, rs1_addr, rs2_addr, rd_addr,
        output uses_rs1, uses_rs2, writes_rd
    );

    // issue control only observes
    modport ctrl (
        input units, rs1_addr, rs2_addr, rd_addr,
        input uses_rs1, uses_rs2, writes_rd
    );

endinterface

`default_nettype wire

// ==== logic/decoder.sv ====
// decoder: combinational unit classification and register usage of one instruction
`default_nettype none

`include "issue_consts.svh"

module decoder (
    input  wire logic [31:0] inst_i,
    decode_if.dec            dec
);

    issue_pkg::rv_opcode_e  opcode;
    issue_pkg::unit_flags_t units;
    logic [6:0]             funct7;
    logic [2:0]             funct3;
    logic                   uses_rs1;
    logic                   uses_rs2;
    logic                   writes_rd;

    // unknown opcode values just miss every case item
    assign opcode = issue_pkg::rv_opcode_e'(inst_i[6:0]);
    assign funct7 = inst_i[31:25];
    assign funct3 = inst_i[14:12];

    // register fields sit at fixed positions in every format
    assign dec.rs1_addr = inst_i[19:15];
    assign dec.rs2_addr = inst_i[24:20];
    assign dec.rd_addr  = inst_i[11:7];

    always_comb begin
        // default: no unit, no register traffic
        units     = '0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            // rs1 op imm -> rd
            issue_pkg::OPC_OP_IMM: begin
                units.alu = 1'b1;
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            // rs1 op rs2 -> rd, either plain alu or the multiplier
            issue_pkg::OPC_OP: begin
                if (funct7 == `FUNCT7_MULDIV) begin
                    // mul, mulh, mulhsu only
                    // mulhu, div and rem have no unit here
                    if (funct3 <= 3'd2) begin
                        units.mul = 1'b1;
                        uses_rs1  = 1'b1;
                        uses_rs2  = 1'b1;
                        writes_rd = 1'b1;
                    end
                end else begin
                    units.alu = 1'b1;
                    uses_rs1  = 1'b1;
                    uses_rs2  = 1'b1;
                    writes_rd = 1'b1;
                end
            end
            // upper immediate -> rd, no source
            issue_pkg::OPC_LUI,
            issue_pkg::OPC_AUIPC: begin
                units.alu = 1'b1;
                writes_rd = 1'b1;
            end
            // link address through the alu, target through the branch unit
            issue_pkg::OPC_JAL: begin
                units.alu = 1'b1;
                units.br  = 1'b1;
                writes_rd = 1'b1;
            end
            // same as jal but the target depends on rs1
            issue_pkg::OPC_JALR: begin
                units.alu = 1'b1;
                units.br  = 1'b1;
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            // compare rs1 with rs2, nothing written back
            issue_pkg::OPC_BRANCH: begin
                units.br = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            // address from rs1, data -> rd
            issue_pkg::OPC_LOAD: begin
                units.lsu = 1'b1;
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            // address from rs1, data from rs2
            issue_pkg::OPC_STORE: begin
                units.lsu = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            default: begin
                units = '0;
            end
        endcase
    end

    assign dec.units     = units;
    assign dec.uses_rs1  = uses_rs1;
    assign dec.uses_rs2  = uses_rs2;
    assign dec.writes_rd = writes_rd;

endmodule

`default_nettype wire

// ==== logic/scoreboard.sv ====
// scoreboard: per-register busy bits with set at issue and clear at writeback
`default_nettype none

`include "issue_consts.svh"

module scoreboard (
    input  wire logic              clk_i,
    input  wire logic              arst_n_i,
    // issue side, marks the destination busy
    input  wire logic              set_i,
    input  wire logic [`REG_AW-1:0] set_rd_i,
    // writeback side, releases a register
    input  wire logic              clr_i,
    input  wire logic [`REG_AW-1:0] clr_rd_i,
    // lookups for the held instruction
    input  wire logic [`REG_AW-1:0] rs1_i,
    input  wire logic [`REG_AW-1:0] rs2_i,
    input  wire logic [`REG_AW-1:0] rd_i,
    output logic                   rs1_busy_o,
    output logic                   rs2_busy_o,
    output logic                   rd_busy_o
);

    logic [`NUM_REGS-1:0] busy_q;
    logic [`NUM_REGS-1:0] busy_d;

    always_comb begin
        busy_d = busy_q;
        // clear first so a set on the same register overrides it
        if (clr_i) begin
            busy_d[clr_rd_i] = 1'b0;
        end
        if (set_i) begin
            busy_d[set_rd_i] = 1'b1;
        end
        // x0 is hardwired zero, never waited on
        busy_d[0] = 1'b0;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_d;
        end
    end

    // lookups see the registered state only
    // a writeback becomes visible the cycle after its edge
    assign rs1_busy_o = busy_q[rs1_i];
    assign rs2_busy_o = busy_q[rs2_i];
    assign rd_busy_o  = busy_q[rd_i];

endmodule

`default_nettype wire

// ==== logic/issue_ctrl.sv ====
// issue_ctrl: one-entry issue register, hazard check, issue pulse and illegal drop
`default_nettype none

`include "issue_consts.svh"

module issue_ctrl (
    input  wire logic                    clk_i,
    input  wire logic                    arst_n_i,
    // instruction input
    input  wire logic                    inst_valid_i,
    input  wire logic [31:0]             inst_i,
    output logic                         inst_ready_o,
    // held word towards the decoder
    output logic [31:0]                  held_inst_o,
    decode_if.ctrl                       dec,
    // scoreboard lookups and update
    input  wire logic                    rs1_busy_i,
    input  wire logic                    rs2_busy_i,
    input  wire logic                    rd_busy_i,
    output logic                         set_o,
    output logic [`REG_AW-1:0]           set_rd_o,
    // issue strobe and payload
    output logic                         issue_valid_o,
    output issue_pkg::unit_flags_t       issue_units_o,
    output logic [`REG_AW-1:0]           issue_rs1_o,
    output logic [`REG_AW-1:0]           issue_rs2_o,
    output logic [`REG_AW-1:0]           issue_rd_o,
    output logic                         illegal_o
);

    issue_pkg::issue_state_e state_q;
    logic [31:0]             inst_q;
    logic                    held;
    logic                    legal;
    logic                    hazard;
    logic                    leave;
    logic                    accept;

    assign held  = (state_q == issue_pkg::HELD);
    // no unit flag means the word has nowhere to go
    assign legal = |dec.units;

    // raw on a source, waw on a real destination
    assign hazard = (dec.uses_rs1 && rs1_busy_i) ||
                    (dec.uses_rs2 && rs2_busy_i) ||
                    (dec.writes_rd && (dec.rd_addr != '0) && rd_busy_i);

    // illegal words carry no usage bits, so they leave at the first chance
    assign leave  = held && !hazard;
    assign accept = inst_valid_i && inst_ready_o;

    // the slot frees up in the same cycle the held word leaves
    assign inst_ready_o = !held || leave;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= issue_pkg::EMPTY;
        end else if (accept) begin
            state_q <= issue_pkg::HELD;
        end else if (leave) begin
            state_q <= issue_pkg::EMPTY;
        end
    end

    // payload only, occupancy lives in state_q
    always_ff @(posedge clk_i) begin
        if (accept) begin
            inst_q <= inst_i;
        end
    end

    assign held_inst_o = inst_q;

    assign issue_valid_o = leave && legal;
    assign illegal_o     = leave && !legal;
    assign issue_units_o = dec.units;
    assign issue_rs1_o   = dec.rs1_addr;
    assign issue_rs2_o   = dec.rs2_addr;
    assign issue_rd_o    = dec.rd_addr;

    // only a real write to x1..x31 books the scoreboard
    assign set_o    = issue_valid_o && dec.writes_rd && (dec.rd_addr != '0);
    assign set_rd_o = dec.rd_addr;

endmodule

`default_nettype wire

// ==== logic/issue_top.sv ====
// issue_top: issue stage top level joining decoder, scoreboard and issue control
`default_nettype none

`include "issue_consts.svh"

module issue_top (
    input  wire logic              clk_i,
    input  wire logic              arst_n_i,
    // instruction input
    input  wire logic              inst_valid_i,
    input  wire logic [31:0]       inst_i,
    output logic                   inst_ready_o,
    // writeback release
    input  wire logic              wb_valid_i,
    input  wire logic [`REG_AW-1:0] wb_rd_i,
    // issue strobe with unit flags
    output logic                   issue_valid_o,
    output logic                   issue_alu_o,
    output logic                   issue_lsu_o,
    output logic                   issue_mul_o,
    output logic                   issue_br_o,
    output logic [`REG_AW-1:0]     issue_rs1_o,
    output logic [`REG_AW-1:0]     issue_rs2_o,
    output logic [`REG_AW-1:0]     issue_rd_o,
    // dropped word strobe
    output logic                   illegal_o
);

    issue_pkg::unit_flags_t issue_units;
    logic [31:0]            held_inst;
    logic                   rs1_busy;
    logic                   rs2_busy;
    logic                   rd_busy;
    logic                   sb_set;
    logic [`REG_AW-1:0]     sb_set_rd;

    decode_if dec_bus ();

    decoder u_decoder (
        .inst_i (held_inst),
        .dec    (dec_bus)
    );

    // lookups use the held word's fields straight from the decoder
    scoreboard u_scoreboard (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .set_i      (sb_set),
        .set_rd_i   (sb_set_rd),
        .clr_i      (wb_valid_i),
        .clr_rd_i   (wb_rd_i),
        .rs1_i      (dec_bus.rs1_addr),
        .rs2_i      (dec_bus.rs2_addr),
        .rd_i       (dec_bus.rd_addr),
        .rs1_busy_o (rs1_busy),
        .rs2_busy_o (rs2_busy),
        .rd_busy_o  (rd_busy)
    );

    issue_ctrl u_issue_ctrl (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .inst_ready_o  (inst_ready_o),
        .held_inst_o   (held_inst),
        .dec           (dec_bus),
        .rs1_busy_i    (rs1_busy),
        .rs2_busy_i    (rs2_busy),
        .rd_busy_i     (rd_busy),
        .set_o         (sb_set),
        .set_rd_o      (sb_set_rd),
        .issue_valid_o (issue_valid_o),
        .issue_units_o (issue_units),
        .issue_rs1_o   (issue_rs1_o),
        .issue_rs2_o   (issue_rs2_o),
        .issue_rd_o    (issue_rd_o),
        .illegal_o     (illegal_o)
    );

    // unit struct out as plain flags
    assign issue_alu_o = issue_units.alu;
    assign issue_lsu_o = issue_units.lsu;
    assign issue_mul_o = issue_units.mul;
    assign issue_br_o  = issue_units.br;

endmodule

`default_nettype wire

// ==== verification/tb_issue.sv ====
// tb_issue: reference model, random stimulus, concurrent assertions and watchdog for issue_top
`default_nettype none

`include "issue_consts.svh"

module tb_issue;

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_INSTS       = 400;
    localparam int WATCHDOG_CYCLES = NUM_INSTS * 40 + 200;

    logic        clk_i;
    logic        arst_n_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic        inst_ready_o;
    logic        wb_valid_i;
    logic [4:0]  wb_rd_i;
    logic        issue_valid_o;
    logic        issue_alu_o;
    logic        issue_lsu_o;
    logic        issue_mul_o;
    logic        issue_br_o;
    logic [4:0]  issue_rs1_o;
    logic [4:0]  issue_rs2_o;
    logic [4:0]  issue_rd_o;
    logic        illegal_o;

    // reference model state
    logic [31:0] model_busy;
    logic [31:0] busy_next;
    logic        model_held;
    logic [31:0] held_word;
    logic        accept_seen;
    int          accepted_count;
    // predictions for the held word, units as {alu, lsu, mul, br}, usage as {rs1, rs2, rd}
    logic [3:0]  exp_units;
    logic [2:0]  exp_use;
    logic        model_hazard;

    issue_top u_dut (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .inst_ready_o  (inst_ready_o),
        .wb_valid_i    (wb_valid_i),
        .wb_rd_i       (wb_rd_i),
        .issue_valid_o (issue_valid_o),
        .issue_alu_o   (issue_alu_o),
        .issue_lsu_o   (issue_lsu_o),
        .issue_mul_o   (issue_mul_o),
        .issue_br_o    (issue_br_o),
        .issue_rs1_o   (issue_rs1_o),
        .issue_rs2_o   (issue_rs2_o),
        .issue_rd_o    (issue_rd_o),
        .illegal_o     (illegal_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // target units per opcode where M codes above funct3 2 go nowhere
    function automatic logic [3:0] expected_units(input logic [31:0] w);
        if (w[6:0] == `OP_OP_IMM || w[6:0] == `OP_LUI || w[6:0] == `OP_AUIPC) return 4'b1000;
        if (w[6:0] == `OP_JAL || w[6:0] == `OP_JALR) return 4'b1001;
        if (w[6:0] == `OP_BRANCH) return 4'b0001;
        if (w[6:0] == `OP_LOAD || w[6:0] == `OP_STORE) return 4'b0100;
        if (w[6:0] == `OP_OP) begin
            if (w[31:25] != `FUNCT7_MULDIV) return 4'b1000;
            return (w[14:12] <= 3'd2) ? 4'b0010 : 4'b0000;
        end
        return 4'b0000;
    endfunction

    // which registers the word waits on and writes
    function automatic logic [2:0] expected_usage(input logic [31:0] w);
        if (expected_units(w) == 4'b0000) return 3'b000;
        case (w[6:0])
            `OP_OP:                return 3'b111;
            `OP_BRANCH, `OP_STORE: return 3'b110;
            `OP_LUI, `OP_AUIPC:    return 3'b001;
            `OP_JAL:               return 3'b001;
            default:               return 3'b101;
        endcase
    endfunction

    // random word over all classes with registers kept in x0..x7 so hazards are common
    function automatic logic [31:0] random_inst();
        logic [31:0] w;
        int          kind;
        w        = $urandom;
        kind     = $urandom % 11;
        w[11:7]  = 5'($urandom % 8);
        w[19:15] = 5'($urandom % 8);
        w[24:20] = 5'($urandom % 8);
        case (kind)
            0: w[6:0] = `OP_OP_IMM;
            1: begin
                w[6:0]   = `OP_OP;
                w[31:25] = ($urandom % 2) ? 7'h20 : 7'h00;
            end
            // funct3 stays random, so div/rem and the upper mul codes show up
            2: begin
                w[6:0]   = `OP_OP;
                w[31:25] = `FUNCT7_MULDIV;
            end
            3: w[6:0] = `OP_LUI;
            4: w[6:0] = `OP_AUIPC;
            5: w[6:0] = `OP_JAL;
            6: w[6:0] = `OP_JALR;
            7: w[6:0] = `OP_BRANCH;
            8: w[6:0] = `OP_LOAD;
            9: w[6:0] = `OP_STORE;
            default: begin
                // fence, system, amo and an all-ones code, none of them handled
                case ($urandom % 4)
                    0:       w[6:0] = 7'b0001111;
                    1:       w[6:0] = 7'b1110011;
                    2:       w[6:0] = 7'b0101111;
                    default: w[6:0] = 7'b1111111;
                endcase
            end
        endcase
        return w;
    endfunction

    // release one busy register now and then
    task automatic drive_writeback();
        int busy_regs[$];
        int pick;
        wb_valid_i = 1'b0;
        for (int r = 1; r < 32; r++) begin
            if (model_busy[r]) busy_regs.push_back(r);
        end
        if (busy_regs.size() > 0 && ($urandom % 2) == 0) begin
            pick       = $urandom % busy_regs.size();
            wb_valid_i = 1'b1;
            wb_rd_i    = 5'(busy_regs[pick]);
        end
    endtask

    always_comb begin
        exp_units    = expected_units(held_word);
        exp_use      = expected_usage(held_word);
        model_hazard = (exp_use[2] && model_busy[held_word[19:15]]) ||
                       (exp_use[1] && model_busy[held_word[24:20]]) ||
                       (exp_use[0] && held_word[11:7] != 5'd0 && model_busy[held_word[11:7]]);
        // clear first so a set on the same register wins
        busy_next = model_busy;
        if (wb_valid_i) busy_next[wb_rd_i] = 1'b0;
        if (issue_valid_o && exp_use[0]) busy_next[held_word[11:7]] = 1'b1;
        busy_next[0] = 1'b0;
    end

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            model_busy     <= '0;
            model_held     <= 1'b0;
            held_word      <= '0;
            accept_seen    <= 1'b0;
            accepted_count <= 0;
        end else begin
            model_busy  <= busy_next;
            accept_seen <= inst_valid_i && inst_ready_o;
            if (inst_valid_i && inst_ready_o) begin
                model_held     <= 1'b1;
                held_word      <= inst_i;
                accepted_count <= accepted_count + 1;
            end else if (issue_valid_o || illegal_o) begin
                model_held <= 1'b0;
            end
        end
    end

    a_reset_state: assert property (@(posedge clk_i)
        !arst_n_i |-> (inst_ready_o && !issue_valid_o && !illegal_o))
        else stop_with_failure($sformatf("[ERROR] %0t: outputs not idle in reset", $time));

    a_issue_units: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        issue_valid_o |-> (model_held &&
            {issue_alu_o, issue_lsu_o, issue_mul_o, issue_br_o} == exp_units))
        else stop_with_failure($sformatf("[ERROR] %0t: unit flags %b for word %h, expected %b",
            $time, {issue_alu_o, issue_lsu_o, issue_mul_o, issue_br_o}, held_word, exp_units));

    a_issue_regs: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        issue_valid_o |-> (issue_rs1_o == held_word[19:15] &&
            issue_rs2_o == held_word[24:20] && issue_rd_o == held_word[11:7]))
        else stop_with_failure($sformatf("[ERROR] %0t: register fields wrong for word %h",
            $time, held_word));

    a_illegal_drop: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        illegal_o |-> (model_held && exp_units == 4'b0000 && !issue_valid_o))
        else stop_with_failure($sformatf("[ERROR] %0t: illegal_o for word %h", $time, held_word));

    a_hazard_order: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        issue_valid_o |-> !model_hazard)
        else stop_with_failure($sformatf("[ERROR] %0t: word %h issued over a busy register",
            $time, held_word));

    // a free legal word leaves in its first held cycle
    a_prompt_issue: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (model_held && !model_hazard && exp_units != 4'b0000) |-> issue_valid_o)
        else stop_with_failure($sformatf("[ERROR] %0t: word %h not issued although free",
            $time, held_word));

    a_prompt_drop: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (model_held && exp_units == 4'b0000) |-> illegal_o)
        else stop_with_failure($sformatf("[ERROR] %0t: illegal word %h not dropped",
            $time, held_word));

    a_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        inst_ready_o == (!model_held || !model_hazard))
        else stop_with_failure($sformatf("[ERROR] %0t: inst_ready_o is %b", $time, inst_ready_o));

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_with_failure("watchdog expired before all instructions left the issue stage");
    end

    initial begin
        void'($urandom(32'h1f8f2676));
        clk_i        = 1'b0;
        arst_n_i     = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        wb_valid_i   = 1'b0;
        wb_rd_i      = '0;
        #5 arst_n_i = 1'b0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i) arst_n_i = 1'b1;
        // hold a word until it is taken, then maybe offer the next one
        while (accepted_count < NUM_INSTS) begin
            @(negedge clk_i);
            drive_writeback();
            if (!inst_valid_i || accept_seen) begin
                if (accepted_count < NUM_INSTS && ($urandom % 4) != 0) begin
                    inst_valid_i = 1'b1;
                    inst_i       = random_inst();
                end else begin
                    inst_valid_i = 1'b0;
                end
            end
        end
        // drain the last word and all pending writebacks
        while (model_held || model_busy != '0) begin
            @(negedge clk_i);
            drive_writeback();
        end
        @(negedge clk_i) wb_valid_i = 1'b0;
        repeat (2) @(posedge clk_i);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+logic
logic/issue_pkg.sv
logic/decode_if.sv
logic/decoder.sv
logic/scoreboard.sv
logic/issue_ctrl.sv
logic/issue_top.sv
verification/tb_issue.sv

// ==== Bender.yml ====
package:
  name: issue_stage

export_include_dirs:
  - logic

sources:
  - files:
      - logic/issue_pkg.sv
      - logic/decode_if.sv
      - logic/decoder.sv
      - logic/scoreboard.sv
      - logic/issue_ctrl.sv
      - logic/issue_top.sv
  - target: test
    files:
      - verification/tb_issue.sv
